// ==== verilog/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  // Datapath width
  localparam int unsigned XLEN = 16;
  // Architectural registers, x0 reads as zero
  localparam int unsigned NR_REGS = 8;
  localparam int unsigned REG_AW = $clog2(NR_REGS);
  // Enough for a scoreboard of up to 8 slots
  localparam int unsigned TRANS_ID_BITS = 3;

  // ----------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_LI  = 3'd5,
    OP_MUL = 3'd6
  } opcode_e;

  // Target execution unit
  typedef enum logic {
    FU_ALU  = 1'b0,
    FU_MULT = 1'b1
  } fu_e;

  // ----------------------------------------------------------
  // Structs
  // ----------------------------------------------------------
  // Instruction as delivered by decode
  typedef struct packed {
    opcode_e           op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   imm;
  } decoded_instr_t;

  // Operands handed to a unit
  typedef struct packed {
    opcode_e                  op;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          operand_b;
    logic [TRANS_ID_BITS-1:0] trans_id;
  } fu_data_t;

  // One writeback port
  typedef struct packed {
    logic                     valid;
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic [XLEN-1:0]          data;
  } wb_t;

  // Result retired from the scoreboard head
  typedef struct packed {
    logic [REG_AW-1:0]        rd;
    logic [XLEN-1:0]          data;
    logic [TRANS_ID_BITS-1:0] trans_id;
  } commit_t;

endpackage

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic [issue_pkg::REG_AW-1:0] raddr_a_i,
  input  logic [issue_pkg::REG_AW-1:0] raddr_b_i,
  output logic [issue_pkg::XLEN-1:0]   rdata_a_o,
  output logic [issue_pkg::XLEN-1:0]   rdata_b_o,
  input  logic                         we_i,
  input  logic [issue_pkg::REG_AW-1:0] waddr_i,
  input  logic [issue_pkg::XLEN-1:0]   wdata_i
);
  import issue_pkg::*;

  logic [NR_REGS-1:0][XLEN-1:0] mem_q;

  // Same-cycle write is visible on the read side
  function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
    if (we_i && (waddr_i == addr) && (addr != '0)) begin
      return wdata_i;
    end
    return mem_q[addr];
  endfunction

  always_comb begin
    rdata_a_o = read_port(raddr_a_i);
    rdata_b_o = read_port(raddr_b_i);
  end

  // x0 stays zero
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mem_q <= '0;
    end else if (we_i && (waddr_i != '0)) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                valid_i,
  input  issue_pkg::fu_data_t fu_data_i,
  output issue_pkg::wb_t      wb_o
);
  import issue_pkg::*;

  logic [XLEN-1:0]          result;
  logic                     valid_q;
  logic [TRANS_ID_BITS-1:0] id_q;
  logic [XLEN-1:0]          data_q;

  always_comb begin
    case (fu_data_i.op)
      OP_ADD:  result = fu_data_i.operand_a + fu_data_i.operand_b;
      OP_SUB:  result = fu_data_i.operand_a - fu_data_i.operand_b;
      OP_AND:  result = fu_data_i.operand_a & fu_data_i.operand_b;
      OP_OR:   result = fu_data_i.operand_a | fu_data_i.operand_b;
      OP_XOR:  result = fu_data_i.operand_a ^ fu_data_i.operand_b;
      // Immediate arrives on operand b
      OP_LI:   result = fu_data_i.operand_b;
      default: result = '0;
    endcase
  end

  // One-cycle writeback pulse
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      id_q   <= fu_data_i.trans_id;
      data_q <= result;
    end
  end

  assign wb_o = '{valid: valid_q, trans_id: id_q, data: data_q};

endmodule

`default_nettype wire

// ==== verilog/mult_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module mult_fsm (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic start_i,
  input  logic last_step_i,
  output logic idle_o,
  output logic step_en_o,
  output logic load_o,
  output logic done_o
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } state_e;

  state_e state_q;
  state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_i) state_d = BUSY;
      // One shift-add step per cycle
      BUSY:    if (last_step_i) state_d = DONE;
      // Writeback cycle, then accept again
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign idle_o    = (state_q == IDLE);
  assign load_o    = (state_q == IDLE) & start_i;
  assign step_en_o = (state_q == BUSY);
  assign done_o    = (state_q == DONE);

endmodule

`default_nettype wire

// ==== verilog/mult_step_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module mult_step_counter (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic clear_i,
  input  logic step_en_i,
  output logic last_step_o
);
  import issue_pkg::*;

  localparam int unsigned CW = $clog2(XLEN);

  logic [CW-1:0] count_q;

  // Restart on every operand load
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (step_en_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  // Step XLEN-1 is the final one
  assign last_step_o = step_en_i & (count_q == CW'(XLEN - 1));

endmodule

`default_nettype wire

// ==== verilog/mult_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module mult_datapath (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                load_i,
  input  logic                step_en_i,
  input  logic                done_i,
  input  issue_pkg::fu_data_t fu_data_i,
  output issue_pkg::wb_t      wb_o
);
  import issue_pkg::*;

  logic [XLEN-1:0]          mcand_q;
  logic [XLEN-1:0]          mplier_q;
  logic [XLEN-1:0]          product_q;
  logic [TRANS_ID_BITS-1:0] id_q;

  // ----------------------------------------------------------
  // Shift-add, low XLEN bits only
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mcand_q   <= '0;
      mplier_q  <= '0;
      product_q <= '0;
      id_q      <= '0;
    end else if (load_i) begin
      mcand_q   <= fu_data_i.operand_a;
      mplier_q  <= fu_data_i.operand_b;
      product_q <= '0;
      id_q      <= fu_data_i.trans_id;
    end else if (step_en_i) begin
      // Accumulate when the current multiplier bit is set
      if (mplier_q[0]) begin
        product_q <= product_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // Result is presented while done is high
  assign wb_o = '{valid: done_i, trans_id: id_q, data: product_q};

endmodule

`default_nettype wire

// ==== verilog/scoreboard.sv ====
`timescale 1ns/100ps
`default_nettype none

module scoreboard #(
  parameter int unsigned NR_SB_ENTRIES = 4,
  localparam int unsigned IDW = $clog2(NR_SB_ENTRIES)
) (
  input  logic                                              clk_i,
  input  logic                                              arst_n_i,
  // Allocation strobe from the issue logic
  input  logic                                              issue_i,
  input  issue_pkg::decoded_instr_t                         issue_instr_i,
  output logic [IDW-1:0]                                    alloc_id_o,
  // Per-slot view used for forwarding
  output logic [NR_SB_ENTRIES-1:0]                          sb_busy_o,
  output logic [NR_SB_ENTRIES-1:0][issue_pkg::REG_AW-1:0]   sb_rd_o,
  output logic [NR_SB_ENTRIES-1:0]                          sb_res_valid_o,
  output logic [NR_SB_ENTRIES-1:0][issue_pkg::XLEN-1:0]     sb_res_o,
  output logic                                              sb_full_o,
  // Writeback ports of the two units
  input  issue_pkg::wb_t                                    alu_wb_i,
  input  issue_pkg::wb_t                                    mult_wb_i,
  // In-order retirement
  output logic                                              commit_valid_o,
  output issue_pkg::commit_t                                commit_o
);
  import issue_pkg::*;

  logic [IDW-1:0]           head_q;
  logic [IDW-1:0]           tail_q;
  logic [IDW:0]             count_q;
  logic [NR_SB_ENTRIES-1:0] alloc_hit;
  logic [NR_SB_ENTRIES-1:0] alu_hit;
  logic [NR_SB_ENTRIES-1:0] mult_hit;

  assign alloc_id_o = tail_q;
  assign sb_full_o  = (count_q == (IDW + 1)'(NR_SB_ENTRIES));

  // Head retires once its result has arrived
  assign commit_valid_o    = sb_busy_o[head_q] & sb_res_valid_o[head_q];
  assign commit_o.rd       = sb_rd_o[head_q];
  assign commit_o.data     = sb_res_o[head_q];
  assign commit_o.trans_id = TRANS_ID_BITS'(head_q);

  // Slot decode for allocation and both writeback ports
  always_comb begin
    for (int i = 0; i < NR_SB_ENTRIES; i++) begin
      alloc_hit[i] = issue_i && (tail_q == IDW'(i));
      alu_hit[i]   = alu_wb_i.valid && (alu_wb_i.trans_id == TRANS_ID_BITS'(i));
      mult_hit[i]  = mult_wb_i.valid && (mult_wb_i.trans_id == TRANS_ID_BITS'(i));
    end
  end

  // ----------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (issue_i) begin
        tail_q <= tail_q + 1'b1;
      end
      if (commit_valid_o) begin
        head_q <= head_q + 1'b1;
      end
      // Issue and commit in one cycle leave the count alone
      case ({issue_i, commit_valid_o})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Slot state
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sb_busy_o      <= '0;
      sb_res_valid_o <= '0;
    end else begin
      for (int i = 0; i < NR_SB_ENTRIES; i++) begin
        if (alloc_hit[i]) begin
          sb_busy_o[i]      <= 1'b1;
          sb_res_valid_o[i] <= 1'b0;
        end
        // Results may land out of order
        if (alu_hit[i] || mult_hit[i]) begin
          sb_res_valid_o[i] <= 1'b1;
        end
        if (commit_valid_o && (head_q == IDW'(i))) begin
          sb_busy_o[i] <= 1'b0;
        end
      end
    end
  end

  // Destination and result payload
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NR_SB_ENTRIES; i++) begin
      if (alloc_hit[i]) begin
        sb_rd_o[i] <= issue_instr_i.rd;
      end
      if (alu_hit[i]) begin
        sb_res_o[i] <= alu_wb_i.data;
      end else if (mult_hit[i]) begin
        sb_res_o[i] <= mult_wb_i.data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/issue_read_operands.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_read_operands #(
  parameter int unsigned NR_SB_ENTRIES = 4,
  localparam int unsigned IDW = $clog2(NR_SB_ENTRIES)
) (
  // Decode handshake
  input  logic                                              instr_valid_i,
  input  issue_pkg::decoded_instr_t                         instr_i,
  output logic                                              instr_ack_o,
  // Register file read ports
  output logic [issue_pkg::REG_AW-1:0]                      rs1_addr_o,
  output logic [issue_pkg::REG_AW-1:0]                      rs2_addr_o,
  input  logic [issue_pkg::XLEN-1:0]                        rs1_data_i,
  input  logic [issue_pkg::XLEN-1:0]                        rs2_data_i,
  // Scoreboard view
  input  logic [IDW-1:0]                                    alloc_id_i,
  input  logic [NR_SB_ENTRIES-1:0]                          sb_busy_i,
  input  logic [NR_SB_ENTRIES-1:0][issue_pkg::REG_AW-1:0]   sb_rd_i,
  input  logic [NR_SB_ENTRIES-1:0]                          sb_res_valid_i,
  input  logic [NR_SB_ENTRIES-1:0][issue_pkg::XLEN-1:0]     sb_res_i,
  input  logic                                              sb_full_i,
  // Unit status and dispatch
  input  logic                                              mult_idle_i,
  output logic                                              alu_valid_o,
  output logic                                              mult_valid_o,
  output issue_pkg::fu_data_t                               fu_data_o
);
  import issue_pkg::*;

  // Resolved source operand
  typedef struct packed {
    logic            stall;
    logic [XLEN-1:0] data;
  } operand_t;

  operand_t op_a;
  operand_t op_b;
  fu_e      fu;
  logic     uses_rs;
  logic     stall;
  logic     unit_free;

  // Youngest busy slot with a matching rd wins
  // Walks from the oldest slot (tail) towards the newest
  function automatic operand_t lookup(input logic [REG_AW-1:0] rs,
                                      input logic [XLEN-1:0]   rf_data);
    operand_t       res;
    logic [IDW-1:0] idx;
    res.stall = 1'b0;
    res.data  = rf_data;
    for (int k = NR_SB_ENTRIES; k >= 1; k--) begin
      idx = alloc_id_i - IDW'(k);
      if (sb_busy_i[idx] && (sb_rd_i[idx] == rs)) begin
        // Pending result blocks issue
        res.stall = ~sb_res_valid_i[idx];
        res.data  = sb_res_i[idx];
      end
    end
    // x0 never depends on anything
    if (rs == '0) begin
      res.stall = 1'b0;
      res.data  = '0;
    end
    return res;
  endfunction

  assign rs1_addr_o = instr_i.rs1;
  assign rs2_addr_o = instr_i.rs2;

  always_comb begin
    op_a = lookup(instr_i.rs1, rs1_data_i);
    op_b = lookup(instr_i.rs2, rs2_data_i);
  end

  // ----------------------------------------------------------
  // Issue decision
  // ----------------------------------------------------------
  assign fu      = (instr_i.op == OP_MUL) ? FU_MULT : FU_ALU;
  // LI reads no registers
  assign uses_rs = (instr_i.op != OP_LI);
  assign stall   = uses_rs & (op_a.stall | op_b.stall);
  // ALU takes one op per cycle on its own port
  // Multiplier only accepts from idle
  assign unit_free = (fu == FU_ALU) | mult_idle_i;

  assign instr_ack_o  = instr_valid_i & ~sb_full_i & ~stall & unit_free;
  assign alu_valid_o  = instr_ack_o & (fu == FU_ALU);
  assign mult_valid_o = instr_ack_o & (fu == FU_MULT);

  always_comb begin
    fu_data_o.op        = instr_i.op;
    fu_data_o.operand_a = op_a.data;
    fu_data_o.operand_b = uses_rs ? op_b.data : instr_i.imm;
    fu_data_o.trans_id  = TRANS_ID_BITS'(alloc_id_i);
  end

endmodule

`default_nettype wire

// ==== verilog/issue_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_stage #(
  parameter int unsigned NR_SB_ENTRIES = 4,
  localparam int unsigned IDW = $clog2(NR_SB_ENTRIES)
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Decode handshake
  input  logic                      instr_valid_i,
  input  issue_pkg::decoded_instr_t instr_i,
  output logic                      instr_ack_o,
  // Commit strobe, no back-pressure
  output logic                      commit_valid_o,
  output issue_pkg::commit_t        commit_o,
  output logic                      sb_full_o
);
  import issue_pkg::*;

  // ----------------------------------------------------------
  // Scoreboard to issue logic
  // ----------------------------------------------------------
  logic [IDW-1:0]                       alloc_id;
  logic [NR_SB_ENTRIES-1:0]             sb_busy;
  logic [NR_SB_ENTRIES-1:0][REG_AW-1:0] sb_rd;
  logic [NR_SB_ENTRIES-1:0]             sb_res_valid;
  logic [NR_SB_ENTRIES-1:0][XLEN-1:0]   sb_res;

  // Register file reads
  logic [REG_AW-1:0] rs1_addr;
  logic [REG_AW-1:0] rs2_addr;
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;

  // Dispatch and writeback
  logic     alu_valid;
  logic     mult_valid;
  fu_data_t fu_data;
  wb_t      alu_wb;
  wb_t      mult_wb;

  // Multiplier control
  logic mult_idle;
  logic mult_load;
  logic mult_step_en;
  logic mult_last_step;
  logic mult_done;

  scoreboard #(
    .NR_SB_ENTRIES(NR_SB_ENTRIES)
  ) i_scoreboard (
    .clk_i,
    .arst_n_i,
    .issue_i       (instr_ack_o),
    .issue_instr_i (instr_i),
    .alloc_id_o    (alloc_id),
    .sb_busy_o     (sb_busy),
    .sb_rd_o       (sb_rd),
    .sb_res_valid_o(sb_res_valid),
    .sb_res_o      (sb_res),
    .sb_full_o,
    .alu_wb_i      (alu_wb),
    .mult_wb_i     (mult_wb),
    .commit_valid_o,
    .commit_o
  );

  issue_read_operands #(
    .NR_SB_ENTRIES(NR_SB_ENTRIES)
  ) i_issue_read_operands (
    .instr_valid_i,
    .instr_i,
    .instr_ack_o,
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .alloc_id_i    (alloc_id),
    .sb_busy_i     (sb_busy),
    .sb_rd_i       (sb_rd),
    .sb_res_valid_i(sb_res_valid),
    .sb_res_i      (sb_res),
    .sb_full_i     (sb_full_o),
    .mult_idle_i   (mult_idle),
    .alu_valid_o   (alu_valid),
    .mult_valid_o  (mult_valid),
    .fu_data_o     (fu_data)
  );

  // Commit writes the architectural state
  reg_file i_reg_file (
    .clk_i,
    .arst_n_i,
    .raddr_a_i(rs1_addr),
    .raddr_b_i(rs2_addr),
    .rdata_a_o(rs1_data),
    .rdata_b_o(rs2_data),
    .we_i     (commit_valid_o),
    .waddr_i  (commit_o.rd),
    .wdata_i  (commit_o.data)
  );

  alu i_alu (
    .clk_i,
    .arst_n_i,
    .valid_i  (alu_valid),
    .fu_data_i(fu_data),
    .wb_o     (alu_wb)
  );

  // ----------------------------------------------------------
  // Iterative multiplier
  // ----------------------------------------------------------
  mult_fsm i_mult_fsm (
    .clk_i,
    .arst_n_i,
    .start_i    (mult_valid),
    .last_step_i(mult_last_step),
    .idle_o     (mult_idle),
    .step_en_o  (mult_step_en),
    .load_o     (mult_load),
    .done_o     (mult_done)
  );

  mult_step_counter i_mult_step_counter (
    .clk_i,
    .arst_n_i,
    .clear_i    (mult_load),
    .step_en_i  (mult_step_en),
    .last_step_o(mult_last_step)
  );

  mult_datapath i_mult_datapath (
    .clk_i,
    .arst_n_i,
    .load_i   (mult_load),
    .step_en_i(mult_step_en),
    .done_i   (mult_done),
    .fu_data_i(fu_data),
    .wb_o     (mult_wb)
  );

endmodule

`default_nettype wire

// ==== test/tb_issue_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_issue_stage;
  import issue_pkg::*;

  // ----------------------------------------------------------
  // Run parameters
  // ----------------------------------------------------------
  localparam int unsigned NR_SB_ENTRIES = 4;
  localparam int unsigned N_INSTR = 400;
  localparam int unsigned RESET_CYCLES = 3;
  localparam int unsigned SEED = 96550;
  // Worst case is a chain of multiplies plus drain
  localparam int unsigned WATCHDOG_CYCLES = N_INSTR * (XLEN + 8) + RESET_CYCLES;

  logic           clk_i;
  logic           arst_n_i;
  logic           instr_valid_i;
  decoded_instr_t instr_i;
  logic           instr_ack_o;
  logic           commit_valid_o;
  commit_t        commit_o;
  logic           sb_full_o;

  // Architectural model state
  logic [XLEN-1:0] arch_q [NR_REGS];
  commit_t         exp_q [$];
  int unsigned     errors;
  int unsigned     acks;
  int unsigned     commits;
  int unsigned     occupancy;
  logic [REG_AW-1:0] prev_rd;

  issue_stage #(
    .NR_SB_ENTRIES(NR_SB_ENTRIES)
  ) dut (
    .clk_i,
    .arst_n_i,
    .instr_valid_i,
    .instr_i,
    .instr_ack_o,
    .commit_valid_o,
    .commit_o,
    .sb_full_o
  );

  // 40 ns period
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Reference result of one instruction
  function automatic logic [XLEN-1:0] expected_result(input opcode_e op,
                                                      input logic [XLEN-1:0] a,
                                                      input logic [XLEN-1:0] b,
                                                      input logic [XLEN-1:0] imm);
    logic [XLEN-1:0] res;
    case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_LI:   res = imm;
      // Low half of the product
      OP_MUL:  res = a * b;
      default: res = '0;
    endcase
    return res;
  endfunction

  // Random instruction with MUL roughly one in five
  function automatic decoded_instr_t random_instr(input logic [REG_AW-1:0] last_rd);
    decoded_instr_t instr;
    instr.op  = ($urandom_range(0, 99) < 20) ? OP_MUL : opcode_e'(3'($urandom_range(0, 5)));
    instr.rd  = REG_AW'($urandom_range(0, NR_REGS - 1));
    instr.rs1 = REG_AW'($urandom_range(0, NR_REGS - 1));
    instr.rs2 = REG_AW'($urandom_range(0, NR_REGS - 1));
    instr.imm = XLEN'($urandom_range(0, (1 << XLEN) - 1));
    // Bias towards back-to-back dependencies
    if ($urandom_range(0, 3) == 0) begin
      instr.rs1 = last_rd;
    end
    if ($urandom_range(0, 3) == 0) begin
      instr.rs2 = last_rd;
    end
    return instr;
  endfunction

  // Push the expected commit of an acked instruction
  task automatic accept_instr(input decoded_instr_t instr);
    commit_t         exp;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    // x0 always reads as zero in the model
    a = (instr.rs1 == '0) ? '0 : arch_q[instr.rs1];
    b = (instr.rs2 == '0) ? '0 : arch_q[instr.rs2];
    exp.rd       = instr.rd;
    exp.data     = expected_result(instr.op, a, b, instr.imm);
    exp.trans_id = TRANS_ID_BITS'(acks % NR_SB_ENTRIES);
    if (instr.rd != '0) begin
      arch_q[instr.rd] = exp.data;
    end
    exp_q.push_back(exp);
  endtask

  // Compare one commit against the queue head
  task automatic check_commit();
    commit_t exp;
    if (exp_q.size() == 0) begin
      $display("Commit seen with no instruction outstanding at %0t", $time);
      errors++;
    end else begin
      exp = exp_q.pop_front();
      if (commit_o.rd != exp.rd) begin
        $display("error: commit_o.rd got %h expected %h", commit_o.rd, exp.rd);
        errors++;
      end
      if (commit_o.data != exp.data) begin
        $display("error: commit_o.data got %h expected %h", commit_o.data, exp.data);
        errors++;
      end
      if (commit_o.trans_id != exp.trans_id) begin
        $display("error: commit_o.trans_id got %h expected %h",
                 commit_o.trans_id, exp.trans_id);
        errors++;
      end
    end
  endtask

  // ----------------------------------------------------------
  // Monitor samples mid-cycle where everything is settled
  // ----------------------------------------------------------
  initial begin : monitor
    forever begin
      @(negedge clk_i);
      if (sb_full_o != (occupancy == NR_SB_ENTRIES)) begin
        $display("error: sb_full_o got %h expected %h",
                 sb_full_o, (occupancy == NR_SB_ENTRIES));
        errors++;
      end
      if (sb_full_o && instr_ack_o) begin
        $display("Instruction acked while the scoreboard was full at %0t", $time);
        errors++;
      end
      // Commit first since it always belongs to an older instruction
      if (commit_valid_o) begin
        check_commit();
        commits++;
        occupancy--;
      end
      if (instr_valid_i && instr_ack_o) begin
        accept_instr(instr_i);
        acks++;
        occupancy++;
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout after %0d cycles, the instruction stream did not drain",
             WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin : stimulus
    void'($urandom(SEED));
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    errors        = 0;
    acks          = 0;
    commits       = 0;
    occupancy     = 0;
    prev_rd       = '0;
    for (int r = 0; r < NR_REGS; r++) begin
      arch_q[r] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    #2 arst_n_i = 1'b1;

    // Quiet outputs before any instruction
    @(negedge clk_i);
    if (instr_ack_o || commit_valid_o || sb_full_o) begin
      $display("error: idle outputs ack/commit/full got %h %h %h expected 0 0 0",
               instr_ack_o, commit_valid_o, sb_full_o);
      errors++;
    end
    @(posedge clk_i);
    #2;

    for (int n = 0; n < N_INSTR; n++) begin
      // Occasional bubble on the decode side
      if ($urandom_range(0, 7) == 0) begin
        instr_valid_i = 1'b0;
        @(posedge clk_i);
        #2;
      end
      instr_i       = random_instr(prev_rd);
      instr_valid_i = 1'b1;
      @(negedge clk_i);
      while (!instr_ack_o) begin
        @(negedge clk_i);
      end
      prev_rd = instr_i.rd;
      @(posedge clk_i);
      #2;
    end
    instr_valid_i = 1'b0;

    // Drain and make sure nothing extra retires
    while (commits != acks) begin
      @(negedge clk_i);
    end
    repeat (4) @(negedge clk_i);

    if (commits != acks || exp_q.size() != 0) begin
      $display("Commit count %0d does not match %0d accepted instructions", commits, acks);
      errors++;
    end
    $display("Summary: %0d errors, %0d acks, %0d commits", errors, acks, commits);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/issue_pkg.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/mult_fsm.sv
verilog/mult_step_counter.sv
verilog/mult_datapath.sv
verilog/scoreboard.sv
verilog/issue_read_operands.sv
verilog/issue_stage.sv
test/tb_issue_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps \
  -f project.f \
  --top-module tb_issue_stage \
  -o sim_tb_issue_stage

./obj_dir/sim_tb_issue_stage > sim.log 2>&1
cat sim.log

if grep -q "^Everything OK$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi
